// ==== Bender.yml ====
package:
  name: ddr3_cache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ddr3_cache_pkg.sv
      - rtl/ddr3_cache_req_fifo.sv
      - rtl/ddr3_cache_set.sv
      - rtl/ddr3_cache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/ddr3_mem_model.sv
      - bench/ddr3_cache_sva.sv
      - bench/ddr3_cache_tb.sv

// ==== bench/ddr3_cache_sva.sv ====
`default_nettype none

module ddr3_cache_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  ack_i,
  input logic                  mem_stb_i,
  input logic                  mem_stall_i,
  input ddr3_cache_pkg::addr_t mem_adr_i,
  input logic                  flush_done_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // quiet while held in reset
  assert property (@(posedge clk) (rst && $past(rst)) |-> (!ack_i && !mem_stb_i))
    else $error("ack_o or mem_stb_o high during reset");

  // stalled strobe keeps its address
  assert property (@(posedge clk) disable iff (rst)
                   (mem_stb_i && mem_stall_i) |=> (mem_stb_i && $stable(mem_adr_i)))
    else $error("memory strobe or address changed while stalled");

  assert property (@(posedge clk) disable iff (rst) flush_done_i |=> !flush_done_i)
    else $error("flush_done_o longer than one cycle");

endmodule

bind ddr3_cache ddr3_cache_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .ack_i        (ack_o),
  .mem_stb_i    (mem_stb_o),
  .mem_stall_i  (mem_stall_i),
  .mem_adr_i    (mem_adr_o),
  .flush_done_i (flush_done_o)
);

`default_nettype wire

// ==== bench/ddr3_cache_tb.sv ====
`default_nettype none

`include "ddr3_cache_macros.svh"

module ddr3_cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETS      = `CACHE_SETS;
  localparam int WAYS      = `CACHE_WAYS;
  localparam int MEM_LINES = 256;
  localparam int WORD_W    = $clog2(MEM_LINES * 4);
  localparam int TIMEOUT   = 1000;

  logic                  clk;
  logic                  rst;
  logic                  flush_start;
  logic                  flush_done;
  logic                  cyc;
  logic                  stb;
  logic                  bus_we;
  ddr3_cache_pkg::addr_t bus_adr;
  ddr3_cache_pkg::sel_t  bus_sel;
  ddr3_cache_pkg::word_t bus_wdat;
  ddr3_cache_pkg::word_t bus_rdat;
  logic                  stall;
  logic                  ack;
  logic                  mem_cyc;
  logic                  mem_stb;
  logic                  mem_we;
  ddr3_cache_pkg::addr_t mem_adr;
  ddr3_cache_pkg::line_t mem_wdat;
  logic                  mem_stall;
  logic                  mem_ack;
  ddr3_cache_pkg::line_t mem_rdat;

  ddr3_cache_pkg::word_t ref_mem [MEM_LINES * 4];
  ddr3_cache_pkg::word_t exp_q [$];
  string                 name_q [$];
  string                 test_name;
  logic                  stall_seen;
  int                    fail_count;

  ddr3_cache #(
    .SETS (SETS),
    .WAYS (WAYS)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .flush_start_i (flush_start),
    .flush_done_o  (flush_done),
    .cyc_i         (cyc),
    .stb_i         (stb),
    .we_i          (bus_we),
    .adr_i         (bus_adr),
    .sel_i         (bus_sel),
    .dat_i         (bus_wdat),
    .stall_o       (stall),
    .ack_o         (ack),
    .dat_o         (bus_rdat),
    .mem_cyc_o     (mem_cyc),
    .mem_stb_o     (mem_stb),
    .mem_we_o      (mem_we),
    .mem_adr_o     (mem_adr),
    .mem_dat_o     (mem_wdat),
    .mem_stall_i   (mem_stall),
    .mem_ack_i     (mem_ack),
    .mem_dat_i     (mem_rdat)
  );

  ddr3_mem_model #(
    .LINES (MEM_LINES)
  ) u_mem (
    .clk         (clk),
    .rst         (rst),
    .mem_cyc_i   (mem_cyc),
    .mem_stb_i   (mem_stb),
    .mem_we_i    (mem_we),
    .mem_adr_i   (mem_adr),
    .mem_dat_i   (mem_wdat),
    .mem_stall_o (mem_stall),
    .mem_ack_o   (mem_ack),
    .mem_dat_o   (mem_rdat)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    fail_count++;
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected)
    begin
      abort_run($sformatf("Error %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // expected read data with unselected lanes zeroed
  function automatic ddr3_cache_pkg::word_t expected_read(ddr3_cache_pkg::addr_t adr,
                                                          ddr3_cache_pkg::sel_t sel);
    ddr3_cache_pkg::word_t word;
    word = ref_mem[adr[WORD_W+1:2]];
    for (int b = 0; b < 4; b++)
    begin
      if (!sel[b])
      begin
        word[b*8 +: 8] = 8'h00;
      end
    end
    return word;
  endfunction

  function automatic void apply_write(ddr3_cache_pkg::addr_t adr, ddr3_cache_pkg::sel_t sel,
                                      ddr3_cache_pkg::word_t dat);
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
      begin
        ref_mem[adr[WORD_W+1:2]][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
  endfunction

  function automatic ddr3_cache_pkg::line_t ref_line(int line);
    return {ref_mem[line*4+3], ref_mem[line*4+2], ref_mem[line*4+1], ref_mem[line*4]};
  endfunction

  function automatic ddr3_cache_pkg::addr_t word_addr(int line, int word);
    return ddr3_cache_pkg::addr_t'(line * 16 + word * 4);
  endfunction

  // request is taken at the next edge with stall low
  task automatic send_request(input logic we, input ddr3_cache_pkg::addr_t adr,
                              input ddr3_cache_pkg::sel_t sel, input ddr3_cache_pkg::word_t dat);
    int waited;
    waited   = 0;
    cyc      = 1'b1;
    stb      = 1'b1;
    bus_we   = we;
    bus_adr  = adr;
    bus_sel  = sel;
    bus_wdat = dat;
    while (stall)
    begin
      stall_seen = 1'b1;
      if (waited == TIMEOUT)
      begin
        abort_run("Bus request held off by stall_o for too long");
      end
      waited++;
      @(posedge clk);
      #10;
    end
    if (we)
    begin
      apply_write(adr, sel, dat);
      exp_q.push_back('0);
    end
    else
    begin
      exp_q.push_back(expected_read(adr, sel));
    end
    name_q.push_back(test_name);
    @(posedge clk);
    #10;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic wait_for_acks();
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      if (waited == TIMEOUT)
      begin
        abort_run("An accepted request never received its acknowledge");
      end
      waited++;
      @(posedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  task automatic run_flush();
    int waited;
    waited      = 0;
    flush_start = 1'b1;
    @(posedge clk);
    #10;
    flush_start = 1'b0;
    while (!flush_done)
    begin
      if (waited == TIMEOUT)
      begin
        abort_run("Flush did not signal completion in time");
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  // one expected value per acknowledge in request order
  always @(negedge clk)
  begin
    if (!rst && ack)
    begin
      if (exp_q.size() == 0)
      begin
        abort_run("Acknowledge seen with no request outstanding");
      end
      else
      begin
        check_value(name_q.pop_front(), exp_q.pop_front(), bus_rdat);
      end
    end
  end

  initial
  begin
    ddr3_cache_pkg::addr_t adrs [$];
    ddr3_cache_pkg::addr_t a;
    int line;
    rst         = 1'b1;
    flush_start = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    bus_we      = 1'b0;
    bus_adr     = '0;
    bus_sel     = '0;
    bus_wdat    = '0;
    stall_seen  = 1'b0;
    fail_count  = 0;
    void'($urandom(83));
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;
    for (int i = 0; i < MEM_LINES * 4; i++)
    begin
      ref_mem[i] = u_mem.mem_q[i / 4][(i % 4)*32 +: 32];
    end

    test_name = "cold_read";
    for (int i = 0; i < 8; i++)
    begin
      a = word_addr($urandom_range(0, 127), $urandom_range(0, 3));
      adrs.push_back(a);
      send_request(1'b0, a, ddr3_cache_pkg::sel_t'($urandom_range(1, 15)), '0);
    end
    wait_for_acks();

    test_name = "repeat_read";
    for (int s = 0; s < 16; s++)
    begin
      send_request(1'b0, adrs[s % 2], ddr3_cache_pkg::sel_t'(s), '0);
    end
    wait_for_acks();

    test_name = "write_merge";
    adrs.delete();
    for (int i = 0; i < 8; i++)
    begin
      a = word_addr($urandom_range(0, 127), $urandom_range(0, 3));
      adrs.push_back(a);
      send_request(1'b1, a, ddr3_cache_pkg::sel_t'($urandom_range(1, 15)), $urandom());
    end
    foreach (adrs[i])
    begin
      send_request(1'b0, adrs[i], 4'hf, '0);
    end
    wait_for_acks();

    // upper half of the lines is untouched so far
    test_name = "dirty_evict";
    for (int t = 0; t < 2 * WAYS; t++)
    begin
      send_request(1'b1, word_addr(128 + t * SETS + 1, t % 4), 4'hf, $urandom());
    end
    wait_for_acks();
    for (int t = 0; t < WAYS; t++)
    begin
      line = 128 + t * SETS + 1;
      check_value("dirty_evict_mem", ref_line(line), u_mem.mem_q[line]);
    end
    for (int t = 0; t < 2 * WAYS; t++)
    begin
      send_request(1'b0, word_addr(128 + t * SETS + 1, t % 4), 4'hf, '0);
    end
    wait_for_acks();

    test_name = "flush";
    run_flush();
    for (int i = 0; i < MEM_LINES; i++)
    begin
      check_value("flush_mem", ref_line(i), u_mem.mem_q[i]);
    end

    test_name  = "random_burst";
    stall_seen = 1'b0;
    for (int i = 0; i < 40; i++)
    begin
      send_request(1'($urandom_range(0, 1)),
                   word_addr($urandom_range(0, MEM_LINES - 1), $urandom_range(0, 3)),
                   ddr3_cache_pkg::sel_t'($urandom_range(1, 15)), $urandom());
    end
    wait_for_acks();
    if (!stall_seen)
    begin
      abort_run("stall_o never rose during the request burst");
    end

    if (fail_count == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/ddr3_mem_model.sv ====
`default_nettype none

module ddr3_mem_model #(
  parameter int LINES = 256
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_cyc_i,
  input  logic                  mem_stb_i,
  input  logic                  mem_we_i,
  input  ddr3_cache_pkg::addr_t mem_adr_i,
  input  ddr3_cache_pkg::line_t mem_dat_i,
  output logic                  mem_stall_o,
  output logic                  mem_ack_o,
  output ddr3_cache_pkg::line_t mem_dat_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IDX_W = $clog2(LINES);

  ddr3_cache_pkg::line_t mem_q [LINES];
  logic                  read_pending;
  logic [IDX_W-1:0]      read_idx;
  int                    ack_delay;
  logic                  taken;

  // preload depends on every bit of the byte address
  initial
  begin
    mem_stall_o  = 1'b0;
    mem_ack_o    = 1'b0;
    mem_dat_o    = '0;
    read_pending = 1'b0;
    read_idx     = '0;
    ack_delay    = 0;
    for (int i = 0; i < LINES; i++)
    begin
      for (int w = 0; w < 4; w++)
      begin
        mem_q[i][w*32 +: 32] = (32'(i * 16 + w * 4) * 32'h9e3779b1) ^ 32'h5ca1ab1e;
      end
    end
  end

  always @(posedge clk)
  begin
    taken = mem_cyc_i && mem_stb_i && !mem_stall_o;
    if (rst)
    begin
      read_pending = 1'b0;
    end
    else if (taken && mem_we_i)
    begin
      mem_q[mem_adr_i[IDX_W+3:4]] = mem_dat_i;
    end
    else if (taken)
    begin
      read_pending = 1'b1;
      read_idx     = mem_adr_i[IDX_W+3:4];
      ack_delay    = $urandom_range(0, 3);
    end
    #10;
    mem_ack_o   = 1'b0;
    mem_stall_o = !rst && ($urandom_range(0, 3) == 0);
    if (read_pending)
    begin
      if (ack_delay == 0)
      begin
        mem_ack_o    = 1'b1;
        mem_dat_o    = mem_q[read_idx];
        read_pending = 1'b0;
      end
      else
      begin
        ack_delay = ack_delay - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ddr3_cache.f ====
+incdir+rtl
rtl/ddr3_cache_pkg.sv
rtl/ddr3_cache_req_fifo.sv
rtl/ddr3_cache_set.sv
rtl/ddr3_cache.sv
bench/ddr3_mem_model.sv
bench/ddr3_cache_sva.sv
bench/ddr3_cache_tb.sv

// ==== rtl/ddr3_cache.sv ====
`default_nettype none

`include "ddr3_cache_macros.svh"

module ddr3_cache #(
  parameter int SETS = `CACHE_SETS,
  parameter int WAYS = `CACHE_WAYS
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  flush_start_i,
  output logic                  flush_done_o,

  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  ddr3_cache_pkg::addr_t adr_i,
  input  ddr3_cache_pkg::sel_t  sel_i,
  input  ddr3_cache_pkg::word_t dat_i,
  output logic                  stall_o,
  output logic                  ack_o,
  output ddr3_cache_pkg::word_t dat_o,

  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  output logic                  mem_we_o,
  output ddr3_cache_pkg::addr_t mem_adr_o,
  output ddr3_cache_pkg::line_t mem_dat_o,
  input  logic                  mem_stall_i,
  input  logic                  mem_ack_i,
  input  ddr3_cache_pkg::line_t mem_dat_i
);

  localparam int ADDR_W = $bits(ddr3_cache_pkg::addr_t);
  localparam int SET_W  = $clog2(SETS);
  localparam int WAY_W  = $clog2(WAYS);
  localparam int REQ_W  = 1 + $bits(ddr3_cache_pkg::sel_t) + ADDR_W
                          + $bits(ddr3_cache_pkg::word_t);

  ddr3_cache_pkg::ctrl_state_t state_q;

  logic                  push;
  logic                  pop;
  logic                  empty;
  logic [REQ_W-1:0]      head;
  logic                  head_we;
  ddr3_cache_pkg::sel_t  head_sel;
  ddr3_cache_pkg::addr_t head_adr;
  ddr3_cache_pkg::word_t head_dat;

  logic [SET_W-1:0]      flush_set_q;
  logic [WAY_W-1:0]      flush_way_q;
  logic                  flush_last;

  logic [SET_W-1:0]      lookup_set;
  ddr3_cache_pkg::addr_t lookup_adr;
  logic [SETS-1:0]       target;

  // per-set lookup results
  logic                  set_hit [SETS];
  logic [WAY_W-1:0]      set_hit_way [SETS];
  logic [WAY_W-1:0]      set_victim_way [SETS];
  logic                  set_victim_dirty [SETS];
  ddr3_cache_pkg::addr_t set_victim_adr [SETS];
  ddr3_cache_pkg::line_t set_rd_line [SETS];
  logic                  set_rd_dirty [SETS];
  ddr3_cache_pkg::addr_t set_rd_adr [SETS];

  logic                  hit;
  logic [WAY_W-1:0]      hit_way;
  logic [WAY_W-1:0]      victim_way;
  logic                  victim_dirty;
  ddr3_cache_pkg::addr_t victim_adr;
  ddr3_cache_pkg::line_t rd_line;
  logic                  rd_dirty;
  ddr3_cache_pkg::addr_t rd_adr;
  ddr3_cache_pkg::word_t rd_word;

  logic                  fill;
  logic                  merge;
  logic                  touch;
  logic                  clean;
  logic [WAY_W-1:0]      rd_way;

  assign push      = cyc_i && stb_i && !stall_o;
  assign {head_we, head_sel, head_adr, head_dat} = head;

  ddr3_cache_req_fifo #(
    .DEPTH (`CACHE_FIFO_DEPTH),
    .WIDTH (REQ_W)
  ) u_req_fifo (
    .clk           (clk),
    .rst           (rst),
    .push_i        (push),
    .push_data_i   ({we_i, sel_i, adr_i, dat_i}),
    .pop_i         (pop),
    .head_o        (head),
    .empty_o       (empty),
    .almost_full_o (stall_o)
  );

  // flush walks the sets by index and requests use the head address
  assign lookup_set = (state_q == ddr3_cache_pkg::st_flush) ? flush_set_q
                                                             : head_adr[SET_W+3:4];
  assign lookup_adr = {head_adr[ADDR_W-1:SET_W+4], lookup_set, head_adr[3:0]};

  for (genvar s = 0; s < SETS; s++)
  begin : gen_set
    assign target[s] = (lookup_set == SET_W'(s));

    ddr3_cache_set #(
      .SETS (SETS),
      .WAYS (WAYS)
    ) u_set (
      .clk            (clk),
      .rst            (rst),
      .target_i       (target[s]),
      .adr_i          (lookup_adr),
      .fill_i         (fill),
      .fill_way_i     (victim_way),
      .fill_line_i    (mem_dat_i),
      .merge_i        (merge),
      .merge_way_i    (hit_way),
      .merge_sel_i    (head_sel),
      .merge_dat_i    (head_dat),
      .touch_i        (touch),
      .clean_i        (clean),
      .clean_way_i    (flush_way_q),
      .rd_way_i       (rd_way),
      .hit_o          (set_hit[s]),
      .hit_way_o      (set_hit_way[s]),
      .victim_way_o   (set_victim_way[s]),
      .victim_dirty_o (set_victim_dirty[s]),
      .victim_adr_o   (set_victim_adr[s]),
      .rd_line_o      (set_rd_line[s]),
      .rd_dirty_o     (set_rd_dirty[s]),
      .rd_adr_o       (set_rd_adr[s])
    );
  end

  assign hit          = set_hit[lookup_set];
  assign hit_way      = set_hit_way[lookup_set];
  assign victim_way   = set_victim_way[lookup_set];
  assign victim_dirty = set_victim_dirty[lookup_set];
  assign victim_adr   = set_victim_adr[lookup_set];
  assign rd_line      = set_rd_line[lookup_set];
  assign rd_dirty     = set_rd_dirty[lookup_set];
  assign rd_adr       = set_rd_adr[lookup_set];

  // victim way stays put from the miss decision until the fill
  always_comb
  begin
    rd_way = victim_way;
    if (state_q == ddr3_cache_pkg::st_flush)
    begin
      rd_way = flush_way_q;
    end
    else if (state_q == ddr3_cache_pkg::st_respond)
    begin
      rd_way = hit_way;
    end
  end

  assign fill  = (state_q == ddr3_cache_pkg::st_load_wait) && mem_ack_i;
  assign merge = (state_q == ddr3_cache_pkg::st_idle) && !flush_start_i && !empty
                 && hit && head_we;
  assign touch = (state_q == ddr3_cache_pkg::st_respond);
  assign pop   = (state_q == ddr3_cache_pkg::st_respond);
  assign clean = (state_q == ddr3_cache_pkg::st_flush) && rd_dirty && !mem_stall_i;

  assign flush_last = (flush_set_q == SET_W'(SETS - 1)) && (flush_way_q == WAY_W'(WAYS - 1));

  // memory port outputs follow the state
  always_comb
  begin
    mem_cyc_o = 1'b0;
    mem_stb_o = 1'b0;
    mem_we_o  = 1'b0;
    mem_adr_o = {head_adr[ADDR_W-1:4], 4'b0000};
    mem_dat_o = rd_line;
    case (state_q)
      ddr3_cache_pkg::st_writeback:
      begin
        mem_cyc_o = 1'b1;
        mem_stb_o = 1'b1;
        mem_we_o  = 1'b1;
        mem_adr_o = victim_adr;
      end
      ddr3_cache_pkg::st_load:
      begin
        mem_cyc_o = 1'b1;
        mem_stb_o = 1'b1;
      end
      ddr3_cache_pkg::st_load_wait:
      begin
        mem_cyc_o = 1'b1;
      end
      ddr3_cache_pkg::st_flush:
      begin
        mem_cyc_o = rd_dirty;
        mem_stb_o = rd_dirty;
        mem_we_o  = rd_dirty;
        mem_adr_o = rd_adr;
      end
      default:
      begin
        mem_cyc_o = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    rd_word = rd_line[head_adr[3:2]*32 +: 32];
    for (int b = 0; b < 4; b++)
    begin
      if (!head_sel[b])
      begin
        rd_word[b*8 +: 8] = 8'h00;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == ddr3_cache_pkg::st_respond)
    begin
      dat_o <= head_we ? '0 : rd_word;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= ddr3_cache_pkg::st_idle;
      ack_o        <= 1'b0;
      flush_done_o <= 1'b0;
      flush_set_q  <= '0;
      flush_way_q  <= '0;
    end
    else
    begin
      ack_o        <= 1'b0;
      flush_done_o <= 1'b0;
      case (state_q)
        ddr3_cache_pkg::st_idle:
        begin
          if (flush_start_i)
          begin
            flush_set_q <= '0;
            flush_way_q <= '0;
            state_q     <= ddr3_cache_pkg::st_flush;
          end
          else if (!empty)
          begin
            // a miss comes back through idle after the fill and then hits
            if (hit)
            begin
              state_q <= ddr3_cache_pkg::st_respond;
            end
            else if (victim_dirty)
            begin
              state_q <= ddr3_cache_pkg::st_writeback;
            end
            else
            begin
              state_q <= ddr3_cache_pkg::st_load;
            end
          end
        end
        ddr3_cache_pkg::st_writeback:
        begin
          if (!mem_stall_i)
          begin
            state_q <= ddr3_cache_pkg::st_load;
          end
        end
        ddr3_cache_pkg::st_load:
        begin
          if (!mem_stall_i)
          begin
            state_q <= ddr3_cache_pkg::st_load_wait;
          end
        end
        ddr3_cache_pkg::st_load_wait:
        begin
          if (mem_ack_i)
          begin
            state_q <= ddr3_cache_pkg::st_idle;
          end
        end
        ddr3_cache_pkg::st_respond:
        begin
          ack_o   <= 1'b1;
          state_q <= ddr3_cache_pkg::st_idle;
        end
        ddr3_cache_pkg::st_flush:
        begin
          // clean lines step at once and dirty ones wait for the memory
          if (!rd_dirty || !mem_stall_i)
          begin
            if (flush_last)
            begin
              flush_done_o <= 1'b1;
              state_q      <= ddr3_cache_pkg::st_idle;
            end
            else if (flush_way_q == WAY_W'(WAYS - 1))
            begin
              flush_way_q <= '0;
              flush_set_q <= flush_set_q + 1'b1;
            end
            else
            begin
              flush_way_q <= flush_way_q + 1'b1;
            end
          end
        end
        default:
        begin
          state_q <= ddr3_cache_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ddr3_cache_macros.svh ====
`ifndef DDR3_CACHE_MACROS_SVH
`define DDR3_CACHE_MACROS_SVH

// default cache geometry
// both powers of two and at least 2
`define CACHE_SETS 4
`define CACHE_WAYS 2

// request FIFO entries
// stall is raised one entry before full
`define CACHE_FIFO_DEPTH 8

// byte address width on the bus side
// bits 3:0 address a byte within a 16-byte line
`define CACHE_ADDR_W 26

`endif

// ==== rtl/ddr3_cache_pkg.sv ====
`default_nettype none

`include "ddr3_cache_macros.svh"

package ddr3_cache_pkg;

  // byte address
  // bits 3:2 pick the word, then set index, then tag
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;

  // bus data word
  typedef logic [31:0] word_t;

  // byte lane select
  // bit n enables bits 8n+7:8n
  typedef logic [3:0] sel_t;

  // one cache line, word 0 in the low bits
  typedef logic [127:0] line_t;

  // controller states
  typedef enum logic [2:0] {
    st_idle,
    st_writeback,
    st_load,
    st_load_wait,
    st_respond,
    st_flush
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/ddr3_cache_req_fifo.sv ====
`default_nettype none

`include "ddr3_cache_macros.svh"

module ddr3_cache_req_fifo #(
  parameter int DEPTH = `CACHE_FIFO_DEPTH,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,

  output logic [WIDTH-1:0] head_o,
  output logic             empty_o,
  output logic             almost_full_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count_q != (PTR_W + 1)'(DEPTH));
  assign do_pop  = pop_i && !empty_o;

  assign head_o        = mem_q[rd_ptr_q];
  assign empty_o       = (count_q == '0);
  // one entry spare for a push in the cycle the flag rises
  assign almost_full_o = (count_q >= (PTR_W + 1)'(DEPTH - 1));

  // entry storage
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (do_push && !do_pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ddr3_cache_set.sv ====
`default_nettype none

`include "ddr3_cache_macros.svh"

module ddr3_cache_set #(
  parameter int SETS = `CACHE_SETS,
  parameter int WAYS = `CACHE_WAYS
) (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      target_i,
  input  ddr3_cache_pkg::addr_t     adr_i,

  input  logic                      fill_i,
  input  logic [$clog2(WAYS)-1:0]   fill_way_i,
  input  ddr3_cache_pkg::line_t     fill_line_i,

  input  logic                      merge_i,
  input  logic [$clog2(WAYS)-1:0]   merge_way_i,
  input  ddr3_cache_pkg::sel_t      merge_sel_i,
  input  ddr3_cache_pkg::word_t     merge_dat_i,

  input  logic                      touch_i,
  input  logic                      clean_i,
  input  logic [$clog2(WAYS)-1:0]   clean_way_i,
  input  logic [$clog2(WAYS)-1:0]   rd_way_i,

  output logic                      hit_o,
  output logic [$clog2(WAYS)-1:0]   hit_way_o,
  output logic [$clog2(WAYS)-1:0]   victim_way_o,
  output logic                      victim_dirty_o,
  output ddr3_cache_pkg::addr_t     victim_adr_o,
  output ddr3_cache_pkg::line_t     rd_line_o,
  output logic                      rd_dirty_o,
  output ddr3_cache_pkg::addr_t     rd_adr_o
);

  localparam int ADDR_W  = $bits(ddr3_cache_pkg::addr_t);
  localparam int SET_W   = $clog2(SETS);
  localparam int TAG_LSB = 4 + SET_W;
  localparam int TAG_W   = ADDR_W - TAG_LSB;
  localparam int WAY_W   = $clog2(WAYS);

  logic [WAYS-1:0]       valid_q;
  logic [WAYS-1:0]       dirty_q;
  logic [TAG_W-1:0]      tag_q [WAYS];
  ddr3_cache_pkg::line_t line_q [WAYS];
  // 0 is most recent, WAYS-1 is the LRU way
  logic [WAY_W-1:0]      age_q [WAYS];

  logic [TAG_W-1:0]      adr_tag;
  logic [1:0]            word_idx;

  assign adr_tag  = adr_i[ADDR_W-1:TAG_LSB];
  assign word_idx = adr_i[3:2];

  always_comb
  begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (valid_q[w] && (tag_q[w] == adr_tag))
      begin
        hit_o     = 1'b1;
        hit_way_o = WAY_W'(w);
      end
    end
  end

  // lowest free way wins over the oldest way
  always_comb
  begin
    victim_way_o = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (age_q[w] == WAY_W'(WAYS - 1))
      begin
        victim_way_o = WAY_W'(w);
      end
    end
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!valid_q[w])
      begin
        victim_way_o = WAY_W'(w);
      end
    end
  end

  assign victim_dirty_o = valid_q[victim_way_o] && dirty_q[victim_way_o];
  assign victim_adr_o   = {tag_q[victim_way_o], adr_i[TAG_LSB-1:4], 4'b0000};

  // writeback and flush read port
  assign rd_line_o  = line_q[rd_way_i];
  assign rd_dirty_o = valid_q[rd_way_i] && dirty_q[rd_way_i];
  assign rd_adr_o   = {tag_q[rd_way_i], adr_i[TAG_LSB-1:4], 4'b0000};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      for (int w = 0; w < WAYS; w++)
      begin
        age_q[w] <= WAY_W'(w);
      end
    end
    else if (target_i)
    begin
      if (fill_i)
      begin
        valid_q[fill_way_i] <= 1'b1;
        dirty_q[fill_way_i] <= 1'b0;
      end
      if (merge_i)
      begin
        dirty_q[merge_way_i] <= 1'b1;
      end
      if (clean_i)
      begin
        dirty_q[clean_way_i] <= 1'b0;
      end
      // hit way becomes youngest and younger ways age by one
      if (touch_i && hit_o)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (WAY_W'(w) == hit_way_o)
          begin
            age_q[w] <= '0;
          end
          else if (age_q[w] < age_q[hit_way_o])
          begin
            age_q[w] <= age_q[w] + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (target_i && fill_i)
    begin
      tag_q[fill_way_i]  <= adr_tag;
      line_q[fill_way_i] <= fill_line_i;
    end
    else if (target_i && merge_i)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (merge_sel_i[b])
        begin
          line_q[merge_way_i][word_idx*32 + b*8 +: 8] <= merge_dat_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire
